//--- src/ptw_pkg.sv
// MMU-side walk request and response types, imported by the walk load port and its testbench
`default_nettype none

package ptw_pkg;

    // ====================
    // Widths
    // ====================
    localparam int unsigned PALEN  = 32;  // Physical address width
    localparam int unsigned DATA_W = 32;  // Loaded page-table word

    // ====================
    // Request
    // ====================
    typedef struct packed {
        logic [PALEN-1:0] pte_pa;  // Physical address of the PTE
    } ptw_req_t;

    // ====================
    // Response
    // ====================
    // Condensed outcome of one walk load, 17 bits
    typedef struct packed {
        logic [3:0] fault_code;
        logic       bus_error;
        logic [7:0] ecc_syndrome;
        logic [2:0] access_class;
        logic       ecc_error;
    } ptw_status_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;  // PTE as loaded
        ptw_status_t       status;
    } ptw_resp_t;

endpackage

`default_nettype wire

//--- src/lsu_pkg.sv
// LSU-side load request, acknowledgement layout and replay back-off constants for the walk port
`default_nettype none

package lsu_pkg;

    // ====================
    // Replay back-off
    // ====================
    localparam int unsigned          BACKOFF_W      = 3;
    localparam logic [BACKOFF_W-1:0] REPLAY_BACKOFF = 3'd7;  // Cycles before reissue

    // ====================
    // Request
    // ====================
    typedef struct packed {
        logic [ptw_pkg::PALEN-1:0] addr;  // Load address
    } lsu_req_t;

    // ====================
    // Acknowledgement
    // ====================
    // Any bit set means the load must be reissued
    typedef struct packed {
        logic bank_conflict;  // Bit 15
        logic resource_busy;  // Bit 14
        logic order_hazard;   // Bit 13
    } lsu_replay_t;

    // 45-bit status word, fields placed at their LSU bit positions
    typedef struct packed {
        logic [9:0]  rsvd_44_35;
        logic [3:0]  fault_code;    // [34:31]
        logic        bus_error;     // [30]
        logic [7:0]  ecc_syndrome;  // [29:22]
        logic [5:0]  rsvd_21_16;
        lsu_replay_t replay;        // [15:13]
        logic [1:0]  rsvd_12_11;
        logic [2:0]  access_class;  // [10:8]
        logic [5:0]  rsvd_7_2;
        logic        ecc_error;     // [1]
        logic        rsvd_0;
    } lsu_ack_status_t;

    typedef struct packed {
        logic [ptw_pkg::DATA_W-1:0] result;
        lsu_ack_status_t            status;
    } lsu_ack_t;

endpackage

`default_nettype wire

//--- src/ptw_half_buffer.sv
// One-entry valid/ready buffer for any packed payload, used on both sides of the walk port
`timescale 1ns/1ps
`default_nettype none

module ptw_half_buffer #(
    parameter type payload_t = logic
) (
    input  wire      core_clk,
    input  wire      core_reset_n,
    // Write side
    input  wire      in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    // Read side
    output logic     out_valid,
    input  wire      out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;
    logic     push;
    logic     pop;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // ====================
    // Occupancy
    // ====================
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            full <= 1'b0;
        end else if (push) begin
            full <= 1'b1;
        end else if (pop) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (push) begin
            data_q <= in_data;  // Captured only when empty
        end
    end

    // Accept and release never overlap, so one item at a time
    assign in_ready  = ~full;
    assign out_valid = full;
    assign out_data  = data_q;

endmodule

`default_nettype wire

//--- src/ptw_issue_ctrl.sv
// Walk load issue FSM, gates the LSU request and tracks the single outstanding load
`timescale 1ns/1ps
`default_nettype none

module ptw_issue_ctrl (
    input  wire  core_clk,
    input  wire  core_reset_n,
    input  wire  entry_valid,    // Request buffer holds an address
    input  wire  backoff_idle,   // No replay back-off running
    output logic lsu_req_valid,
    input  wire  lsu_req_ready,
    input  wire  lsu_ack_valid
);

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   outstanding;
    logic   issue_fire;

    assign outstanding = (state_q == WAIT_ACK);
    assign issue_fire  = lsu_req_valid & lsu_req_ready;

    // Held while the LSU stalls, nothing below can drop it
    assign lsu_req_valid = ~outstanding & entry_valid & backoff_idle;

    // ====================
    // Next state
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (issue_fire) begin
                    state_d = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (lsu_ack_valid) begin
                    state_d = IDLE;  // Replay or completion alike
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

//--- src/ptw_retry_timer.sv
// Replay back-off timer, holds off reissue of a replayed walk load for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module ptw_retry_timer (
    input  wire  core_clk,
    input  wire  core_reset_n,
    input  wire  start,  // Replay ack seen
    output logic idle
);

    import lsu_pkg::*;

    logic [BACKOFF_W-1:0] cnt_q;

    // ====================
    // Down counter
    // ====================
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            cnt_q <= '0;
        end else if (start) begin
            cnt_q <= REPLAY_BACKOFF;  // Reload even mid-count
        end else if (!idle) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Low from the cycle after start, back high REPLAY_BACKOFF cycles later
    assign idle = (cnt_q == '0);

endmodule

`default_nettype wire

//--- src/ptw_resp_format.sv
// Splits an LSU ack into replay or completion and condenses its status for the MMU response
`timescale 1ns/1ps
`default_nettype none

module ptw_resp_format (
    input  wire                lsu_ack_valid,
    input  lsu_pkg::lsu_ack_t  lsu_ack,
    output logic               replay,
    output logic               complete,
    output ptw_pkg::ptw_resp_t resp
);

    import ptw_pkg::*;
    import lsu_pkg::*;

    lsu_ack_status_t ack_status;
    ptw_status_t     status;
    logic            any_replay;

    assign ack_status = lsu_ack.status;
    assign any_replay = |ack_status.replay;

    // ====================
    // Classification
    // ====================
    assign replay   = lsu_ack_valid & any_replay;
    assign complete = lsu_ack_valid & ~any_replay;

    // ====================
    // Condensing
    // ====================
    // Replay group and reserved bits do not reach the MMU
    assign status.fault_code   = ack_status.fault_code;
    assign status.bus_error    = ack_status.bus_error;
    assign status.ecc_syndrome = ack_status.ecc_syndrome;
    assign status.access_class = ack_status.access_class;
    assign status.ecc_error    = ack_status.ecc_error;

    assign resp.data   = lsu_ack.result;
    assign resp.status = status;

endmodule

`default_nettype wire

//--- src/ptw_lsu_port.sv
// Page-table-walk load port top level, takes one PTE address from the MMU and loads it via the LSU
`timescale 1ns/1ps
`default_nettype none

module ptw_lsu_port (
    input  wire                core_clk,
    input  wire                core_reset_n,
    // MMU request
    input  wire                mmu_req_valid,
    output logic               mmu_req_ready,
    input  ptw_pkg::ptw_req_t  mmu_req,
    // MMU response
    output logic               mmu_resp_valid,
    input  wire                mmu_resp_ready,
    output ptw_pkg::ptw_resp_t mmu_resp,
    // LSU request
    output logic               lsu_req_valid,
    input  wire                lsu_req_ready,
    output lsu_pkg::lsu_req_t  lsu_req,
    // LSU acknowledgement, always accepted
    input  wire                lsu_ack_valid,
    input  lsu_pkg::lsu_ack_t  lsu_ack
);

    import ptw_pkg::*;
    import lsu_pkg::*;

    logic      req_buf_in_valid;
    logic      req_buf_in_ready;
    logic      req_entry_valid;
    ptw_req_t  req_entry;
    logic      resp_buf_in_ready;
    logic      ack_replay;
    logic      ack_complete;
    ptw_resp_t resp_formatted;
    logic      backoff_idle;

    // ====================
    // Request side
    // ====================
    // A full response buffer keeps the next walk out
    assign req_buf_in_valid = mmu_req_valid & resp_buf_in_ready;
    assign mmu_req_ready    = req_buf_in_ready & resp_buf_in_ready;

    ptw_half_buffer #(
        .payload_t (ptw_req_t)
    ) u_req_buf (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .in_valid     (req_buf_in_valid),
        .in_ready     (req_buf_in_ready),
        .in_data      (mmu_req),
        .out_valid    (req_entry_valid),
        .out_ready    (ack_complete),     // Freed on completion only
        .out_data     (req_entry)
    );

    assign lsu_req = lsu_req_t'{addr: req_entry.pte_pa};

    ptw_issue_ctrl u_issue (
        .core_clk      (core_clk),
        .core_reset_n  (core_reset_n),
        .entry_valid   (req_entry_valid),
        .backoff_idle  (backoff_idle),
        .lsu_req_valid (lsu_req_valid),
        .lsu_req_ready (lsu_req_ready),
        .lsu_ack_valid (lsu_ack_valid)
    );

    ptw_retry_timer u_backoff (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .start        (ack_replay),
        .idle         (backoff_idle)
    );

    // ====================
    // Response side
    // ====================
    ptw_resp_format u_format (
        .lsu_ack_valid (lsu_ack_valid),
        .lsu_ack       (lsu_ack),
        .replay        (ack_replay),
        .complete      (ack_complete),
        .resp          (resp_formatted)
    );

    // Empty whenever a load is outstanding, so a completion always lands
    ptw_half_buffer #(
        .payload_t (ptw_resp_t)
    ) u_resp_buf (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .in_valid     (ack_complete),
        .in_ready     (resp_buf_in_ready),
        .in_data      (resp_formatted),
        .out_valid    (mmu_resp_valid),
        .out_ready    (mmu_resp_ready),
        .out_data     (mmu_resp)
    );

endmodule

`default_nettype wire

//--- verif/ptw_lsu_port_sva.sv
// Bound assertions for the walk load port, checks stalled payloads, one load in flight and back-off
`timescale 1ns/1ps
`default_nettype none

module ptw_lsu_port_sva (
    input wire                core_clk,
    input wire                core_reset_n,
    input wire                lsu_req_valid,
    input wire                lsu_req_ready,
    input lsu_pkg::lsu_req_t  lsu_req,
    input wire                lsu_ack_valid,
    input lsu_pkg::lsu_ack_t  lsu_ack,
    input wire                mmu_resp_valid,
    input wire                mmu_resp_ready,
    input ptw_pkg::ptw_resp_t mmu_resp
);

    import lsu_pkg::*;

    logic                 lsu_fire;
    logic                 replay_ack;
    logic                 in_flight_q;  // Between LSU transfer and its ack
    logic [BACKOFF_W-1:0] holdoff_q;    // Cycles left before a reissue is legal

    assign lsu_fire   = lsu_req_valid & lsu_req_ready;
    assign replay_ack = lsu_ack_valid & (|lsu_ack.status.replay);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            in_flight_q <= 1'b0;
            holdoff_q   <= '0;
        end else begin
            if (lsu_fire) begin
                in_flight_q <= 1'b1;
            end else if (lsu_ack_valid) begin
                in_flight_q <= 1'b0;
            end
            if (replay_ack) begin
                holdoff_q <= REPLAY_BACKOFF;
            end else if (holdoff_q != '0) begin
                holdoff_q <= holdoff_q - 1'b1;
            end
        end
    end

    // ====================
    // Properties
    // ====================
    lsu_req_stable: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        lsu_req_valid && !lsu_req_ready |=> lsu_req_valid && $stable(lsu_req))
        else $error("lsu_req dropped or changed while stalled");

    mmu_resp_stable: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        mmu_resp_valid && !mmu_resp_ready |=> mmu_resp_valid && $stable(mmu_resp))
        else $error("mmu_resp dropped or changed while stalled");

    single_load: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        lsu_fire |-> !in_flight_q)
        else $error("second LSU load issued before the ack");

    replay_holdoff: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        holdoff_q != '0 |-> !lsu_req_valid)
        else $error("LSU request raised during replay back-off");

endmodule

bind ptw_lsu_port ptw_lsu_port_sva u_sva (
    .core_clk       (core_clk),
    .core_reset_n   (core_reset_n),
    .lsu_req_valid  (lsu_req_valid),
    .lsu_req_ready  (lsu_req_ready),
    .lsu_req        (lsu_req),
    .lsu_ack_valid  (lsu_ack_valid),
    .lsu_ack        (lsu_ack),
    .mmu_resp_valid (mmu_resp_valid),
    .mmu_resp_ready (mmu_resp_ready),
    .mmu_resp       (mmu_resp)
);

`default_nettype wire

//--- verif/ptw_lsu_port_tb.sv
// Table-driven testbench for the walk load port, with a behavioral LSU and random ready stalls
`timescale 1ns/1ps
`default_nettype none

module ptw_lsu_port_tb;

    import ptw_pkg::*;
    import lsu_pkg::*;

    localparam int NUM_WALKS    = 6;
    localparam int RESET_CYCLES = 16;
    localparam int REISSUE_GAP  = 8;  // Replay ack to reissued request

    logic      core_clk = 1'b0;
    logic      core_reset_n;
    logic      mmu_req_valid;
    logic      mmu_req_ready;
    ptw_req_t  mmu_req;
    logic      mmu_resp_valid;
    logic      mmu_resp_ready = 1'b0;
    ptw_resp_t mmu_resp;
    logic      lsu_req_valid;
    logic      lsu_req_ready  = 1'b0;
    lsu_req_t  lsu_req;
    logic      lsu_ack_valid  = 1'b0;
    lsu_ack_t  lsu_ack        = '0;

    // Walk table and expected responses
    logic [31:0] tbl_addr    [NUM_WALKS];
    int          tbl_replays [NUM_WALKS];
    int          tbl_rbit    [NUM_WALKS];
    logic [31:0] tbl_result  [NUM_WALKS];
    logic [16:0] tbl_status  [NUM_WALKS];
    logic [48:0] exp_resp    [NUM_WALKS];
    int          exp_xfers   [NUM_WALKS];  // LSU requests seen by the end of each walk

    int   cycle = 0;
    int   check_cnt = 0;
    int   error_cnt = 0;
    int   resp_cnt = 0;
    int   lsu_xfer_cnt = 0;
    int   lsu_walk = 0;
    int   replays_done = 0;
    int   ack_delay = 0;
    int   replay_cycle = 0;
    logic load_busy = 1'b0;
    logic reissue_pending = 1'b0;

    ptw_lsu_port u_dut (.*);

    always #20 core_clk = ~core_clk;

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        error_cnt++;
        $display("ERROR: %s", msg);
    endtask

    task automatic add_walk(input int idx, input logic [31:0] addr, input int replays,
                            input int rbit, input logic [31:0] result, input logic [3:0] fault,
                            input logic bus, input logic [7:0] syn, input logic [2:0] cls,
                            input logic ecc);
        tbl_addr[idx]    = addr;
        tbl_replays[idx] = replays;
        tbl_rbit[idx]    = rbit;
        tbl_result[idx]  = result;
        tbl_status[idx]  = {fault, bus, syn, cls, ecc};
        exp_resp[idx]    = {result, fault, bus, syn, cls, ecc};  // Replay and reserved dropped
        exp_xfers[idx]   = (idx == 0 ? 0 : exp_xfers[idx - 1]) + replays + 1;
    endtask

    // ====================
    // LSU model
    // ====================
    always @(posedge core_clk) begin : lsu_model
        lsu_ack_t ack;
        ack           = '0;
        cycle         <= cycle + 1;
        lsu_ack_valid <= 1'b0;
        if (core_reset_n) begin
            if (reissue_pending && lsu_req_valid) begin
                compare_value("reissue_delay", cycle - replay_cycle, REISSUE_GAP);
                reissue_pending <= 1'b0;
            end
            if (lsu_req_valid && lsu_req_ready) begin
                if (load_busy || lsu_walk >= NUM_WALKS) begin
                    report_failure("LSU request issued while no walk load was expected");
                end else begin
                    compare_value("lsu_req.addr", lsu_req.addr, tbl_addr[lsu_walk]);
                end
                lsu_xfer_cnt <= lsu_xfer_cnt + 1;
                load_busy    <= 1'b1;
                ack_delay    <= 1 + ($urandom % 5);
            end else if (load_busy && ack_delay > 1) begin
                ack_delay <= ack_delay - 1;
            end else if (load_busy) begin
                ack.status = '1;  // Reserved bits set on every ack
                if (replays_done < tbl_replays[lsu_walk]) begin
                    ack.result        = $urandom;
                    ack.status.replay = lsu_replay_t'(3'b001 << tbl_rbit[lsu_walk]);
                    replays_done    <= replays_done + 1;
                    reissue_pending <= 1'b1;
                    replay_cycle    <= cycle + 1;  // Edge where the DUT sees the ack
                end else begin
                    ack.result              = tbl_result[lsu_walk];
                    ack.status.replay       = '0;
                    {ack.status.fault_code, ack.status.bus_error, ack.status.ecc_syndrome,
                     ack.status.access_class, ack.status.ecc_error} = tbl_status[lsu_walk];
                    replays_done <= 0;
                    lsu_walk     <= lsu_walk + 1;
                end
                lsu_ack       <= ack;
                lsu_ack_valid <= 1'b1;
                load_busy     <= 1'b0;
            end
        end
    end

    // Random back-pressure on both ready inputs
    always @(posedge core_clk) begin
        lsu_req_ready  <= ($urandom % 4) != 0;
        mmu_resp_ready <= ($urandom % 3) != 0;
    end

    // ====================
    // Response checker
    // ====================
    always @(posedge core_clk) begin
        if (core_reset_n && mmu_resp_valid && mmu_resp_ready) begin
            if (resp_cnt >= NUM_WALKS) begin
                report_failure("MMU response seen with no walk pending");
            end else begin
                compare_value("mmu_resp", mmu_resp, exp_resp[resp_cnt]);
                compare_value("lsu_req count", lsu_xfer_cnt, exp_xfers[resp_cnt]);
            end
            resp_cnt <= resp_cnt + 1;
        end
    end

    initial begin : stimulus
        int seed_word;
        seed_word     = $urandom(74);
        core_reset_n  = 1'b0;
        mmu_req_valid = 1'b0;
        mmu_req       = '0;
        add_walk(0, 32'h8000_1000, 0, 0, 32'h2000_0C01, 4'h0, 1'b0, 8'h00, 3'd1, 1'b0);
        add_walk(1, 32'h8000_2008, 1, 0, 32'hDEAD_BEEF, 4'h5, 1'b0, 8'h00, 3'd2, 1'b0);
        add_walk(2, 32'h8004_7FF8, 2, 1, 32'h0000_00CF, 4'hD, 1'b1, 8'h00, 3'd3, 1'b0);
        add_walk(3, 32'hFFFF_F000, 3, 2, 32'h1234_5678, 4'h0, 1'b0, 8'hA5, 3'd7, 1'b1);
        add_walk(4, 32'h0000_0010, 1, 2, 32'hCAFE_F00D, 4'h7, 1'b1, 8'h3C, 3'd0, 1'b1);
        add_walk(5, 32'h8000_3010, 0, 1, 32'h0BAD_0001, 4'hF, 1'b0, 8'hFF, 3'd5, 1'b0);
        repeat (RESET_CYCLES) @(posedge core_clk);
        core_reset_n <= 1'b1;
        @(posedge core_clk);
        compare_value("lsu_req_valid", lsu_req_valid, 1'b0);
        compare_value("mmu_resp_valid", mmu_resp_valid, 1'b0);
        compare_value("mmu_req_ready", mmu_req_ready, 1'b1);
        for (int i = 0; i < NUM_WALKS; i++) begin
            mmu_req_valid <= 1'b1;
            mmu_req       <= '{pte_pa: tbl_addr[i]};
            @(posedge core_clk);
            while (!mmu_req_ready) begin
                @(posedge core_clk);
            end
            compare_value("responses taken at accept", resp_cnt, i);  // Previous walk done
        end
        mmu_req_valid <= 1'b0;
        while (resp_cnt < NUM_WALKS) begin
            @(posedge core_clk);
        end
        repeat (20) @(posedge core_clk);
        compare_value("lsu_req total", lsu_xfer_cnt, exp_xfers[NUM_WALKS - 1]);
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_WALKS * 200) @(posedge core_clk);
        report_failure("timeout, the walks did not finish in time");
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
src/ptw_pkg.sv
src/lsu_pkg.sv
src/ptw_half_buffer.sv
src/ptw_issue_ctrl.sv
src/ptw_retry_timer.sv
src/ptw_resp_format.sv
src/ptw_lsu_port.sv
verif/ptw_lsu_port_sva.sv
verif/ptw_lsu_port_tb.sv

//--- Bender.yml
package:
  name: ptw_lsu_port

sources:
  # Packages first, MMU side before LSU side
  - src/ptw_pkg.sv
  - src/lsu_pkg.sv
  # RTL
  - src/ptw_half_buffer.sv
  - src/ptw_issue_ctrl.sv
  - src/ptw_retry_timer.sv
  - src/ptw_resp_format.sv
  - src/ptw_lsu_port.sv
  # Verification
  - target: test
    files:
      - verif/ptw_lsu_port_sva.sv
      - verif/ptw_lsu_port_tb.sv
